// File: Makefile
# Verilator build and run for the audio mixer testbench

VERILATOR ?= verilator
TOP       ?= tb_audio_mixer
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

FAIL_MSG  := Some tests failed
SRCS      := $(wildcard source/*.sv testbench/*.sv)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
source/audio_pkg.sv
source/audio_apb_regs.sv
source/mix_channel.sv
source/sigma_delta_dac.sv
source/audio_mixer_top.sv
testbench/audio_mixer_sva.sv
testbench/tb_audio_mixer.sv

// File: source/audio_apb_regs.sv
// APB slave holding the mixer control and per-channel sample registers,
// plus the free-running divider that makes the 2 MHz sample strobe
`timescale 1ns/10ps

module audio_apb_regs (
	input  logic                                 clk_32,
	input  logic                                 xsint,      // async, active low
	// apb slave
	input  logic [audio_pkg::APB_AW-1:0]         paddr_i,
	input  logic                                 psel_i,
	input  logic                                 penable_i,
	input  logic                                 pwrite_i,
	input  logic [audio_pkg::APB_DW-1:0]         pwdata_i,
	output logic [audio_pkg::APB_DW-1:0]         prdata_o,
	output logic                                 pready_o,
	output logic                                 pslverr_o,
	// to the mixing channels
	output logic                                 ym_en_o,
	output logic                                 dma_en_o,
	output logic [audio_pkg::N_CHANNELS-1:0][audio_pkg::YM_W-1:0]  ym_level_o,
	output logic [audio_pkg::N_CHANNELS-1:0][audio_pkg::DMA_W-1:0] dma_sample_o,
	output logic                                 sample_stb_o
);

	import audio_pkg::*;

	logic [APB_AW-3:0] word_idx;  // byte address / 4
	logic              access;    // apb access phase
	logic              bad_idx;
	logic              wr_en;
	logic [APB_DW-1:0] rd_data;

	logic                                ym_en_q;
	logic                                dma_en_q;
	logic [N_CHANNELS-1:0][YM_W-1:0]     ym_level_q;
	logic [N_CHANNELS-1:0][DMA_W-1:0]    dma_sample_q;

	logic [$clog2(STROBE_DIV)-1:0]       div_cnt;
	logic                                stb_q;

	assign word_idx = paddr_i[APB_AW-1:2]; // low two bits ignored
	assign access   = psel_i & penable_i;
	assign bad_idx  = int'(word_idx) > 2 * N_CHANNELS;
	assign wr_en    = access & pwrite_i & ~bad_idx;

	// no wait states, ready on every access phase
	assign pready_o  = access;
	assign pslverr_o = access & bad_idx;
	assign prdata_o  = (access & ~pwrite_i) ? rd_data : '0;

	// read mux, unused bits stay zero
	always_comb begin
		rd_data = '0;
		if (int'(word_idx) == REG_CTRL) begin
			rd_data[CTRL_YM_EN_BIT]  = ym_en_q;
			rd_data[CTRL_DMA_EN_BIT] = dma_en_q;
		end
		for (int c = 0; c < N_CHANNELS; c++) begin
			if (int'(word_idx) == REG_CH_BASE + 2 * c)
				rd_data[YM_W-1:0] = ym_level_q[c];      // level word
			if (int'(word_idx) == REG_CH_BASE + 2 * c + 1)
				rd_data[DMA_W-1:0] = dma_sample_q[c];   // sample word
		end
	end

	// register writes at the end of the access phase
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ym_en_q      <= 1'b0;
			dma_en_q     <= 1'b0;
			ym_level_q   <= '0;
			dma_sample_q <= '0;
		end else if (wr_en) begin
			if (int'(word_idx) == REG_CTRL) begin
				ym_en_q  <= pwdata_i[CTRL_YM_EN_BIT];
				dma_en_q <= pwdata_i[CTRL_DMA_EN_BIT];
			end
			for (int c = 0; c < N_CHANNELS; c++) begin
				if (int'(word_idx) == REG_CH_BASE + 2 * c)
					ym_level_q[c] <= pwdata_i[YM_W-1:0];
				if (int'(word_idx) == REG_CH_BASE + 2 * c + 1)
					dma_sample_q[c] <= pwdata_i[DMA_W-1:0];
			end
		end
	end

	// sample strobe divider
	// counter runs from reset, pulse is one clk_32 wide
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			div_cnt <= '0;
			stb_q   <= 1'b0;
		end else begin
			stb_q <= int'(div_cnt) == STROBE_DIV - 1; // one pulse per wrap
			if (int'(div_cnt) == STROBE_DIV - 1)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	assign ym_en_o      = ym_en_q;
	assign dma_en_o     = dma_en_q;
	assign ym_level_o   = ym_level_q;
	assign dma_sample_o = dma_sample_q;
	assign sample_stb_o = stb_q;

endmodule

// File: source/audio_mixer_top.sv
// audio mixer top: APB register file, one mixing channel per output and the
// sigma-delta dac producing one bitstream per channel on audio_o
`timescale 1ns/10ps

module audio_mixer_top (
	input  logic                                 clk_32,
	input  logic                                 xsint,
	input  logic [audio_pkg::APB_AW-1:0]         paddr_i,
	input  logic                                 psel_i,
	input  logic                                 penable_i,
	input  logic                                 pwrite_i,
	input  logic [audio_pkg::APB_DW-1:0]         pwdata_i,
	output logic [audio_pkg::APB_DW-1:0]         prdata_o,
	output logic                                 pready_o,
	output logic                                 pslverr_o,
	output logic [audio_pkg::N_CHANNELS-1:0]     audio_o    // 0 = left, 1 = right
);

	import audio_pkg::*;

	logic                              ym_en;
	logic                              dma_en;
	logic                              sample_stb;
	logic [N_CHANNELS-1:0][YM_W-1:0]   ym_level;
	logic [N_CHANNELS-1:0][DMA_W-1:0]  dma_sample;
	logic [N_CHANNELS-1:0][MIX_W-1:0]  mix;        // signed mix per channel

	audio_apb_regs regs_i (
		.clk_32       ( clk_32     ),
		.xsint        ( xsint      ),
		.paddr_i      ( paddr_i    ),
		.psel_i       ( psel_i     ),
		.penable_i    ( penable_i  ),
		.pwrite_i     ( pwrite_i   ),
		.pwdata_i     ( pwdata_i   ),
		.prdata_o     ( prdata_o   ),
		.pready_o     ( pready_o   ),
		.pslverr_o    ( pslverr_o  ),
		.ym_en_o      ( ym_en      ),
		.dma_en_o     ( dma_en     ),
		.ym_level_o   ( ym_level   ),
		.dma_sample_o ( dma_sample ),
		.sample_stb_o ( sample_stb )
	);

	genvar c;
	generate
		for (c = 0; c < N_CHANNELS; c++) begin : g_ch
			mix_channel mix_i (
				.clk_32       ( clk_32        ),
				.xsint        ( xsint         ),
				.ym_en_i      ( ym_en         ),
				.dma_en_i     ( dma_en        ),
				.sample_stb_i ( sample_stb    ),
				.ym_level_i   ( ym_level[c]   ),
				.dma_sample_i ( dma_sample[c] ),
				.mix_o        ( mix[c]        )
			);
		end
	endgenerate

	sigma_delta_dac dac_i (
		.clk_32  ( clk_32  ),
		.xsint   ( xsint   ),
		.mix_i   ( mix     ),
		.audio_o ( audio_o )
	);

endmodule

// File: source/audio_pkg.sv
// shared constants for the audio mixer: widths, channel count, APB register map
// and the sample strobe divider; imported by every design module
package audio_pkg;

	// channel count, 0 = left, 1 = right
	localparam int N_CHANNELS = 2;

	// source and mix widths
	localparam int YM_W  = 10; // sound chip level, offset binary
	localparam int DMA_W = 8;  // dma sound sample, offset binary
	localparam int MIX_W = 15; // signed sum fed to the dac

	// apb port
	localparam int APB_AW = 5;
	localparam int APB_DW = 16;

	// register map in word indices, byte address is index * 4
	localparam int REG_CTRL    = 0;
	localparam int REG_CH_BASE = 1; // level at 1 + 2c, sample at 2 + 2c

	// control register bits
	localparam int CTRL_YM_EN_BIT  = 0;
	localparam int CTRL_DMA_EN_BIT = 1;

	// clk_32 cycles per sample strobe, 32 MHz / 16 = 2 MHz
	localparam int STROBE_DIV = 16;

endpackage

// File: source/mix_channel.sv
// one mixing channel that makes the sound chip level and the dma sample signed,
// widens both to the mix width and sums them; result held between sample strobes
`timescale 1ns/10ps

module mix_channel (
	input  logic                              clk_32,
	input  logic                              xsint,
	input  logic                              ym_en_i,      // level source enable
	input  logic                              dma_en_i,     // sample source enable
	input  logic                              sample_stb_i, // 2 MHz pulse
	input  logic [audio_pkg::YM_W-1:0]        ym_level_i,   // offset binary
	input  logic [audio_pkg::DMA_W-1:0]       dma_sample_i, // offset binary
	output logic signed [audio_pkg::MIX_W-1:0] mix_o
);

	import audio_pkg::*;

	logic [YM_W-1:0]         ym_s;      // level minus midpoint
	logic [DMA_W-1:0]        dma_s;     // sample minus midpoint
	logic signed [MIX_W-1:0] ym_term;
	logic signed [MIX_W-1:0] dma_term;
	logic signed [MIX_W-1:0] mix_sum;
	logic signed [MIX_W-1:0] mix_q;

	// offset binary to two's complement by removing the msb weight
	assign ym_s  = ym_level_i - {1'b1, {(YM_W - 1){1'b0}}};    // -512
	assign dma_s = dma_sample_i - {1'b1, {(DMA_W - 1){1'b0}}}; // -128

	// widen to MIX_W
	// sign repeated once on top and top bits of the value copied below
	// so each source spans half the mix range
	always_comb begin
		ym_term = '0;
		if (ym_en_i)
			ym_term = {ym_s[YM_W-1], ym_s, ym_s[YM_W-1 -: (MIX_W - YM_W - 1)]};
	end

	always_comb begin
		dma_term = '0;
		if (dma_en_i)
			dma_term = {dma_s[DMA_W-1], dma_s, dma_s[DMA_W-1 -: (MIX_W - DMA_W - 1)]};
	end

	assign mix_sum = ym_term + dma_term; // wraps at MIX_W

	// latch on the strobe only
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			mix_q <= '0;
		else if (sample_stb_i)
			mix_q <= mix_sum;
	end

	assign mix_o = mix_q;

endmodule

// File: source/sigma_delta_dac.sv
// first-order sigma-delta dac, one modulator per channel; each output bit
// has a ones density of (mix + 2^(MIX_W-1)) / 2^MIX_W
`timescale 1ns/10ps

module sigma_delta_dac (
	input  logic                                                   clk_32,
	input  logic                                                   xsint,
	input  logic [audio_pkg::N_CHANNELS-1:0][audio_pkg::MIX_W-1:0] mix_i, // signed per channel
	output logic [audio_pkg::N_CHANNELS-1:0]                       audio_o  // bitstreams
);

	import audio_pkg::*;

	logic [N_CHANNELS-1:0] bit_q;

	genvar c;
	generate
		for (c = 0; c < N_CHANNELS; c++) begin : g_mod
			logic [MIX_W-1:0] u_val; // mix in offset binary
			logic [MIX_W:0]   sum;   // accumulator plus carry
			logic [MIX_W-1:0] acc_q;

			// flip sign bit, -16384..16383 maps to 0..32767
			assign u_val = {~mix_i[c][MIX_W-1], mix_i[c][MIX_W-2:0]};
			assign sum   = {1'b0, acc_q} + {1'b0, u_val};

			always_ff @(posedge clk_32 or negedge xsint) begin
				if (!xsint) begin
					acc_q    <= '0;
					bit_q[c] <= 1'b0;
				end else begin
					acc_q    <= sum[MIX_W-1:0]; // keep the remainder
					bit_q[c] <= sum[MIX_W];     // carry is the output bit
				end
			end
		end
	endgenerate

	assign audio_o = bit_q;

endmodule

// File: testbench/audio_mixer_sva.sv
// concurrent checks on the mixer APB port and reset state, bound into the top;
// failures are counted in fail_cnt, which the testbench reads at the end
`timescale 1ns/10ps

module audio_mixer_sva (
	input logic                                clk_32,
	input logic                                xsint,
	input logic [audio_pkg::APB_AW-1:0]        paddr_i,
	input logic                                psel_i,
	input logic                                penable_i,
	input logic [audio_pkg::APB_DW-1:0]        prdata_o,
	input logic                                pready_o,
	input logic                                pslverr_o,
	input logic [audio_pkg::N_CHANNELS-1:0]    audio_o
);

	import audio_pkg::*;

	int   fail_cnt = 0; // failed assertions so far
	logic access;
	logic bad_idx;

	assign access  = psel_i & penable_i;
	assign bad_idx = int'(paddr_i[APB_AW-1:2]) > 2 * N_CHANNELS; // past last channel word

	// zero wait states
	ready_in_access: assert property (@(posedge clk_32) disable iff (!xsint)
		access |-> pready_o)
	else begin
		fail_cnt++;
		$error("pready_o low during an APB access phase");
	end

	slverr_only_bad: assert property (@(posedge clk_32) disable iff (!xsint)
		pslverr_o |-> (access && bad_idx))
	else begin
		fail_cnt++;
		$error("pslverr_o high outside an access phase with a bad index");
	end

	audio_quiet_in_reset: assert property (@(posedge clk_32)
		!xsint |-> (audio_o == '0))
	else begin
		fail_cnt++;
		$error("audio_o not zero while xsint is low");
	end

	apb_idle_in_reset: assert property (@(posedge clk_32)
		!xsint |-> (!pready_o && !pslverr_o && prdata_o == '0))
	else begin
		fail_cnt++;
		$error("APB outputs not zero while xsint is low");
	end

endmodule

bind audio_mixer_top audio_mixer_sva sva_i (
	.clk_32    ( clk_32    ),
	.xsint     ( xsint     ),
	.paddr_i   ( paddr_i   ),
	.psel_i    ( psel_i    ),
	.penable_i ( penable_i ),
	.prdata_o  ( prdata_o  ),
	.pready_o  ( pready_o  ),
	.pslverr_o ( pslverr_o ),
	.audio_o   ( audio_o   )
);

// File: testbench/tb_audio_mixer.sv
// testbench for audio_mixer_top: APB register access, bad index, and bitstream
// ones counting per channel against the mix rule; run with -f project.f
`timescale 1ns/10ps

module tb_audio_mixer;

	import audio_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int READY_LIMIT = 8;  // cycles allowed for pready_o
	localparam int BAD_IDX     = 7;

	logic                  clk_32 = 1'b0;
	logic                  xsint;
	logic [APB_AW-1:0]     paddr;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_DW-1:0]     pwdata;
	logic [APB_DW-1:0]     prdata_o;
	logic                  pready_o;
	logic                  pslverr_o;
	logic [N_CHANNELS-1:0] audio_o;

	logic [15:0]           lfsr_q;
	logic [1:0]            shadow_ctrl;  // expected register contents
	logic [YM_W-1:0]       shadow_lvl [N_CHANNELS];
	logic [DMA_W-1:0]      shadow_smp [N_CHANNELS];
	int                    value_errs;
	int                    timeout_errs;
	int                    sva_errs;
	logic [APB_DW-1:0]     rd;
	logic                  err;

	audio_mixer_top dut_i (
		.clk_32    ( clk_32    ),
		.xsint     ( xsint     ),
		.paddr_i   ( paddr     ),
		.psel_i    ( psel      ),
		.penable_i ( penable   ),
		.pwrite_i  ( pwrite    ),
		.pwdata_i  ( pwdata    ),
		.prdata_o  ( prdata_o  ),
		.pready_o  ( pready_o  ),
		.pslverr_o ( pslverr_o ),
		.audio_o   ( audio_o   )
	);

	always #(CLK_PERIOD / 2) clk_32 = ~clk_32;

	// galois lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [APB_DW-1:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
			val    = {val[APB_DW-2:0], lfsr_q[0]};
		end
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp) else begin
			value_errs++;
			$display("error: %s got %h expected %h", name, got, exp);
		end
	endtask

	// one APB transfer, setup then access, sampled mid low phase
	task automatic apb_access(input logic wr, input int idx, input logic [APB_DW-1:0] wdata,
			output logic [APB_DW-1:0] rdata, output logic slverr);
		int waited;
		waited = 0;
		@(negedge clk_32);
		paddr   = APB_AW'(idx * 4);
		pwrite  = wr;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk_32);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		while (!pready_o && waited < READY_LIMIT) begin
			@(negedge clk_32);
			#(CLK_PERIOD / 4);
			waited++;
		end
		if (!pready_o) begin
			timeout_errs++;
			$display("timeout: pready_o never rose for word index %0d", idx);
		end
		rdata  = prdata_o;
		slverr = pslverr_o;
		@(negedge clk_32); // transfer done at the rising edge before
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_reg(input int idx, input logic [APB_DW-1:0] data);
		apb_access(1'b1, idx, data, rd, err);
		check_value($sformatf("pslverr_o on write %0d", idx), int'(err), 0);
	endtask

	task automatic expect_reg(input int idx, input int exp);
		apb_access(1'b0, idx, '0, rd, err);
		check_value($sformatf("pslverr_o on read %0d", idx), int'(err), 0);
		check_value($sformatf("prdata_o word %0d", idx), int'(rd), exp);
	endtask

	task automatic check_all_regs();
		expect_reg(REG_CTRL, int'(shadow_ctrl));
		for (int c = 0; c < N_CHANNELS; c++) begin
			expect_reg(REG_CH_BASE + 2 * c, int'(shadow_lvl[c]));
			expect_reg(REG_CH_BASE + 2 * c + 1, int'(shadow_smp[c]));
		end
	endtask

	task automatic set_ctrl(input logic [APB_DW-1:0] val);
		write_reg(REG_CTRL, val);
		shadow_ctrl = val[1:0]; // only the two enables exist
	endtask

	task automatic load_channel(input int c);
		logic [APB_DW-1:0] val;
		draw_bits(APB_DW, val);
		write_reg(REG_CH_BASE + 2 * c, val);
		shadow_lvl[c] = val[YM_W-1:0];
		draw_bits(APB_DW, val);
		write_reg(REG_CH_BASE + 2 * c + 1, val);
		shadow_smp[c] = val[DMA_W-1:0];
	endtask

	// signed source s of width w placed in the mix: sign doubled, top bits below
	function automatic int widen_term(input int s, input int w);
		int k;
		k = MIX_W - w - 1; // bits appended below
		return s * (1 << k) + ((s & ((1 << w) - 1)) >> (w - k));
	endfunction

	function automatic int expected_ones(input int c);
		int mix;
		mix = 0;
		if (shadow_ctrl[CTRL_YM_EN_BIT])
			mix += widen_term(int'(shadow_lvl[c]) - (1 << (YM_W - 1)), YM_W);
		if (shadow_ctrl[CTRL_DMA_EN_BIT])
			mix += widen_term(int'(shadow_smp[c]) - (1 << (DMA_W - 1)), DMA_W);
		return mix + (1 << (MIX_W - 1)); // offset binary density
	endfunction

	// let the mix settle, then count ones over one full accumulator period
	task automatic check_mix_window();
		int ones [N_CHANNELS];
		repeat (2 * STROBE_DIV) @(negedge clk_32);
		foreach (ones[c])
			ones[c] = 0;
		repeat (1 << MIX_W) begin
			@(negedge clk_32);
			for (int c = 0; c < N_CHANNELS; c++)
				ones[c] += int'(audio_o[c]);
		end
		for (int c = 0; c < N_CHANNELS; c++)
			check_value($sformatf("audio_o[%0d] ones", c), ones[c], expected_ones(c));
	endtask

	initial begin
		xsint        = 1'b0;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		lfsr_q       = 16'd45646;
		shadow_ctrl  = '0;
		value_errs   = 0;
		timeout_errs = 0;
		foreach (shadow_lvl[c]) begin
			shadow_lvl[c] = '0;
			shadow_smp[c] = '0;
		end
		repeat (4) @(negedge clk_32);
		xsint = 1'b1;

		check_all_regs(); // everything zero out of reset

		// random readback, masked to width
		draw_bits(APB_DW, rd);
		set_ctrl(rd);
		for (int c = 0; c < N_CHANNELS; c++)
			load_channel(c);
		check_all_regs();

		// out of range index errors and writes nothing
		draw_bits(APB_DW, rd);
		apb_access(1'b1, BAD_IDX, rd, rd, err);
		check_value("pslverr_o on bad write", int'(err), 1);
		apb_access(1'b0, BAD_IDX, '0, rd, err);
		check_value("pslverr_o on bad read", int'(err), 1);
		check_all_regs();

		// both sources
		for (int c = 0; c < N_CHANNELS; c++)
			load_channel(c);
		set_ctrl(16'h0003);
		check_mix_window();

		set_ctrl(16'h0001); // level alone
		check_mix_window();
		set_ctrl(16'h0002); // sample alone
		check_mix_window();
		set_ctrl(16'h0000); // silence, exactly half density
		check_mix_window();

		sva_errs = dut_i.sva_i.fail_cnt;
		$display("errors: value %0d, timeout %0d, assertion %0d",
			value_errs, timeout_errs, sva_errs);
		if (value_errs + timeout_errs + sva_errs == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
